/* dla_params.svh */
// Grid size, walker margins, spawn offset, shift register lengths and seeds
`ifndef DLA_PARAMS_SVH
`define DLA_PARAMS_SVH

// Grid geometry, scaled-down display
`define DLA_GRID_W     64
`define DLA_GRID_H     64
`define DLA_X_BITS     6            // Column coordinate width
`define DLA_Y_BITS     6            // Row coordinate width

// Walker limits
// Lowest reachable coordinate. Highest is grid size minus 8
`define DLA_MARGIN     4
`define DLA_SPAWN_OFS  10           // Added to a 5-bit random field on spawn

// XOR shift registers
`define DLA_XR_BITS    31
`define DLA_YR_BITS    29

// Alternating ones and zeros, trimmed to length
`define DLA_XR_SEED    31'h5555_5555
`define DLA_YR_SEED    29'h1555_5555

`endif

/* dla_geom_pkg.sv */
// Grid coordinate types and the cell address union
`default_nettype none

package dla_geom_pkg;

`include "dla_params.svh"

   // -------------------------------------------------------------------------
   // Coordinates
   // -------------------------------------------------------------------------
   typedef logic [`DLA_X_BITS-1:0] coord_x_t;   // Column, 0 at left
   typedef logic [`DLA_Y_BITS-1:0] coord_y_t;   // Row, 0 at top

   // -------------------------------------------------------------------------
   // Cell address
   // -------------------------------------------------------------------------
   // Walker side works in x/y, memory side in a flat index.
   // Row in the upper bits, so idx = y*64 + x
   typedef union packed
   {
      struct packed
      {
         coord_y_t y;                             // Row, upper bits
         coord_x_t x;                             // Column, lower bits
      } xy;
      logic [`DLA_X_BITS+`DLA_Y_BITS-1:0] idx;   // Flat memory index
   } cell_addr_u;

endpackage

`default_nettype wire

/* dla_ctrl_pkg.sv */
// Grid operation codes, walker FSM states and the neighbour count type
`default_nettype none

package dla_ctrl_pkg;

   // Operations the walker can ask of the grid access unit
   typedef enum logic [1:0]
   {
      clear_all = 2'd0,   // Sweep every cell to zero
      probe     = 2'd1,   // Sum of the four neighbours
      set_cell  = 2'd2    // Write a one at addr
   } grid_op_t;

   // Walker FSM
   typedef enum logic [2:0]
   {
      clearing   = 3'd0,
      seeding    = 3'd1,
      probing    = 3'd2,
      stepping   = 3'd3,
      freezing   = 3'd4,
      spawning   = 3'd5,
      idle_pause = 3'd6
   } walk_state_t;

   typedef logic [2:0] nsum_t;   // 0 to 4 set neighbours

endpackage

`default_nettype wire

/* dla_ifs.sv */
// Grid request interface and frame buffer port interface, with modports
`timescale 1ns/1ps
`default_nettype none

// ---------------------------------------------------------------------------
// Four-phase request from the walker to the grid access unit
// ---------------------------------------------------------------------------
interface grid_req_if;
   import dla_geom_pkg::*;
   import dla_ctrl_pkg::*;

   logic       req;    // Held until ack seen
   logic       ack;    // Held until req drops
   grid_op_t   op;     // Stable while req high
   cell_addr_u addr;   // Stable while req high
   nsum_t      sum;    // Probe result, valid with ack

   modport walker (output req, output op, output addr, input ack, input sum);
   modport access (input req, input op, input addr, output ack, output sum);
endinterface

// ---------------------------------------------------------------------------
// Frame buffer write/read port, read data one cycle after raddr
// ---------------------------------------------------------------------------
interface buf_port_if;
   import dla_geom_pkg::*;

   cell_addr_u waddr;
   logic       wdata;
   logic       we;
   cell_addr_u raddr;
   logic       rdata;   // Registered in the memory

   modport master
   (
      output waddr, output wdata, output we, output raddr,
      input  rdata
   );
   modport memory
   (
      input  waddr, input wdata, input we, input raddr,
      output rdata
   );
endinterface

`default_nettype wire

/* random_source.sv */
// Pair of XOR shift registers feeding the walker direction and spawn position
`timescale 1ns/1ps
`default_nettype none
`include "dla_params.svh"

module random_source (
   input  wire logic                    VGA_CTRL_CLK,
   input  wire logic                    reset,
   input  wire logic                    step,   // Walker consumed the values
   input  wire logic                    run,    // Low while paused
   output logic [`DLA_XR_BITS-1:0]      xr,
   output logic [`DLA_YR_BITS-1:0]      yr
);

   logic x_fb;   // Feedback bits
   logic y_fb;

   // Taps at 27/30 and 26/28
   assign x_fb = xr[27] ^ xr[`DLA_XR_BITS-1];
   assign y_fb = yr[26] ^ yr[`DLA_YR_BITS-1];

   always_ff @(posedge VGA_CTRL_CLK)
   begin
      if (reset)
      begin
         xr <= `DLA_XR_SEED;
         yr <= `DLA_YR_SEED;
      end
      // Free-running while paused, so a pause reshapes the pattern
      else if (step || !run)
      begin
         xr <= {xr[`DLA_XR_BITS-2:0], x_fb};   // Shift left, fb in at LSB
         yr <= {yr[`DLA_YR_BITS-2:0], y_fb};
      end
   end

endmodule

`default_nettype wire

/* grid_access.sv */
// Grid access unit: clear sweep, four-neighbour probe and single cell write
`timescale 1ns/1ps
`default_nettype none

module grid_access (
   input wire logic     VGA_CTRL_CLK,
   input wire logic     reset,
   grid_req_if.access   grid,
   buf_port_if.master   mem
);
   import dla_geom_pkg::*;
   import dla_ctrl_pkg::*;

   // FSM encoding
   localparam logic [2:0] ga_idle  = 3'd0;
   localparam logic [2:0] ga_clear = 3'd1;   // Sweeping zeros
   localparam logic [2:0] ga_probe = 3'd2;   // Four reads in flight
   localparam logic [2:0] ga_write = 3'd3;   // Single set_cell write
   localparam logic [2:0] ga_ack   = 3'd4;   // Waiting for req to fall

   localparam logic [$bits(cell_addr_u)-1:0] clr_last = '1;

   logic [2:0] state;
   logic [2:0] phase;   // Probe pipeline step

   // Neighbour address: 0 left, 1 right, 2 up, 3 down
   function automatic cell_addr_u nbr_addr(input logic [1:0] sel, input cell_addr_u a);
      cell_addr_u n;
      n = a;
      case (sel)
         2'd0:    n.xy.x = a.xy.x - 1'b1;
         2'd1:    n.xy.x = a.xy.x + 1'b1;
         2'd2:    n.xy.y = a.xy.y - 1'b1;
         default: n.xy.y = a.xy.y + 1'b1;
      endcase
      return n;
   endfunction

   // ------------------------------------------------------------------------
   // Control: FSM, ack, write enable
   // ------------------------------------------------------------------------
   always_ff @(posedge VGA_CTRL_CLK)
   begin
      if (reset)
      begin
         state    <= ga_idle;
         phase    <= '0;
         grid.ack <= 1'b0;
         mem.we   <= 1'b0;
      end
      else
      begin
         case (state)
            ga_idle:
               if (grid.req)   // ack always low here
               begin
                  phase <= '0;
                  case (grid.op)
                     clear_all:
                     begin
                        mem.we <= 1'b1;
                        state  <= ga_clear;
                     end
                     probe: state <= ga_probe;
                     default:   // set_cell
                     begin
                        mem.we <= 1'b1;
                        state  <= ga_write;
                     end
                  endcase
               end
            ga_clear:
               // Last address goes out with ack, written on the next edge
               if (mem.waddr.idx == clr_last - 1'b1)
               begin
                  grid.ack <= 1'b1;
                  state    <= ga_ack;
               end
            ga_probe:
            begin
               phase <= phase + 1'b1;
               if (phase == 3'd4)   // Lower neighbour summed this edge
               begin
                  grid.ack <= 1'b1;
                  state    <= ga_ack;
               end
            end
            ga_write:
            begin
               mem.we   <= 1'b0;   // Cell written this edge
               grid.ack <= 1'b1;
               state    <= ga_ack;
            end
            default:   // ga_ack
            begin
               mem.we <= 1'b0;
               if (!grid.req)
               begin
                  grid.ack <= 1'b0;
                  state    <= ga_idle;
               end
            end
         endcase
      end
   end

   // ------------------------------------------------------------------------
   // Datapath: addresses, write data, neighbour sum
   // ------------------------------------------------------------------------
   always_ff @(posedge VGA_CTRL_CLK)
   begin
      case (state)
         ga_idle:
         begin
            grid.sum  <= '0;
            mem.wdata <= (grid.op == set_cell);   // Zero for the sweep
            mem.raddr <= nbr_addr(2'd0, grid.addr);   // Left first
            if (grid.op == clear_all)
               mem.waddr.idx <= '0;
            else
               mem.waddr <= grid.addr;
         end
         ga_clear: mem.waddr.idx <= mem.waddr.idx + 1'b1;
         ga_probe:
         begin
            if (phase < 3'd3)
               mem.raddr <= nbr_addr(phase[1:0] + 2'd1, grid.addr);
            if (phase != 3'd0)   // Data lags address by one
               grid.sum <= grid.sum + nsum_t'(mem.rdata);
         end
         default: ;
      endcase
   end

endmodule

`default_nettype wire

/* walker_ctrl.sv */
// Walker FSM: clear, seed the centre, then probe, step, freeze and respawn
`timescale 1ns/1ps
`default_nettype none
`include "dla_params.svh"

module walker_ctrl (
   input  wire logic                    VGA_CTRL_CLK,
   input  wire logic                    reset,
   input  wire logic                    run,
   input  wire logic [`DLA_XR_BITS-1:0] xr,
   input  wire logic [`DLA_YR_BITS-1:0] yr,
   output logic                         step,      // Random words consumed
   grid_req_if.walker                   grid,
   output logic                         ready,     // Clear and seed done
   output logic                         stuck,     // Walker just frozen
   output dla_geom_pkg::coord_x_t       stuck_x,
   output dla_geom_pkg::coord_y_t       stuck_y
);
   import dla_geom_pkg::*;
   import dla_ctrl_pkg::*;

   // Walk limits and fixed positions
   localparam coord_x_t lo_x    = coord_x_t'(`DLA_MARGIN);
   localparam coord_x_t hi_x    = coord_x_t'(`DLA_GRID_W - 8);
   localparam coord_y_t lo_y    = coord_y_t'(`DLA_MARGIN);
   localparam coord_y_t hi_y    = coord_y_t'(`DLA_GRID_H - 8);
   localparam coord_x_t mid_x   = coord_x_t'(`DLA_GRID_W / 2);
   localparam coord_y_t mid_y   = coord_y_t'(`DLA_GRID_H / 2);
   localparam coord_x_t start_x = mid_x - 2'd2;   // First walker, just left of centre

   walk_state_t state;
   walk_state_t resume;    // Where to go after a pause
   coord_x_t    wx;        // Walker position
   coord_y_t    wy;
   coord_x_t    edge_pos;  // Spawn offset along an edge
   logic        hs_done;   // ack seen, req dropping now

   assign hs_done  = grid.req && grid.ack;
   assign edge_pos = {1'b0, xr[`DLA_XR_BITS-2 -: 5]} + coord_x_t'(`DLA_SPAWN_OFS);

   // Op follows state; state and position hold while req is high
   always_comb
   begin
      grid.op        = probe;
      grid.addr.xy.x = wx;
      grid.addr.xy.y = wy;
      case (state)
         clearing:          grid.op = clear_all;
         seeding, freezing: grid.op = set_cell;
         default: ;
      endcase
   end

   // ------------------------------------------------------------------------
   // FSM and handshake
   // ------------------------------------------------------------------------
   always_ff @(posedge VGA_CTRL_CLK)
   begin
      if (reset)
      begin
         state    <= clearing;
         resume   <= clearing;
         grid.req <= 1'b0;
         ready    <= 1'b0;
         stuck    <= 1'b0;
         step     <= 1'b0;
      end
      else
      begin
         stuck <= 1'b0;   // Single-cycle strobes
         step  <= 1'b0;
         case (state)
            stepping, spawning:
            begin
               step  <= 1'b1;   // Fresh random bits for next move
               state <= probing;
            end
            idle_pause:
               if (run)
                  state <= resume;
            default:   // States that issue a grid request
               if (!grid.req && !grid.ack)
               begin
                  if (run)
                     grid.req <= 1'b1;
                  else
                  begin
                     resume <= state;
                     state  <= idle_pause;
                  end
               end
               else if (hs_done)
               begin
                  grid.req <= 1'b0;
                  case (state)
                     clearing: state <= seeding;
                     seeding:
                     begin
                        ready <= 1'b1;   // Sticks until reset
                        state <= probing;
                     end
                     probing: state <= (grid.sum != '0) ? freezing : stepping;
                     default:   // freezing
                     begin
                        stuck <= 1'b1;
                        state <= spawning;
                     end
                  endcase
               end
         endcase
      end
   end

   // ------------------------------------------------------------------------
   // Walker position and frozen cell
   // ------------------------------------------------------------------------
   always_ff @(posedge VGA_CTRL_CLK)
   begin
      case (state)
         clearing:
            if (hs_done)   // Seed goes at the centre
            begin
               wx <= mid_x;
               wy <= mid_y;
            end
         seeding:
            if (hs_done)   // First walker near the top
            begin
               wx <= start_x;
               wy <= lo_y;
            end
         stepping:
         begin
            if (xr[`DLA_XR_BITS-1] && wx < hi_x)
               wx <= wx + 1'b1;
            else if (!xr[`DLA_XR_BITS-1] && wx > lo_x)
               wx <= wx - 1'b1;
            if (yr[`DLA_YR_BITS-1] && wy < hi_y)
               wy <= wy + 1'b1;
            else if (!yr[`DLA_YR_BITS-1] && wy > lo_y)
               wy <= wy - 1'b1;
         end
         freezing:
            if (hs_done)
            begin
               stuck_x <= wx;
               stuck_y <= wy;
            end
         spawning:
            if (xr[`DLA_XR_BITS-1])   // Top or bottom edge
            begin
               wx <= edge_pos;
               wy <= yr[`DLA_YR_BITS-1] ? hi_y : lo_y;
            end
            else   // Left or right edge
            begin
               wy <= coord_y_t'(edge_pos);
               wx <= yr[`DLA_YR_BITS-1] ? hi_x : lo_x;
            end
         default: ;
      endcase
   end

endmodule

`default_nettype wire

/* cell_buffer.sv */
// One-bit frame buffer with an engine port and a registered scan read port
`timescale 1ns/1ps
`default_nettype none
`include "dla_params.svh"

module cell_buffer (
   input  wire logic                      VGA_CTRL_CLK,
   buf_port_if.memory                     mem,
   input  wire dla_geom_pkg::cell_addr_u  scan_addr,   // Display refresh side
   output logic                           pixel_on
);

   localparam int unsigned depth = `DLA_GRID_W * `DLA_GRID_H;

   logic cells [0:depth-1];   // One bit per cell, set = aggregate

   // ------------------------------------------------------------------------
   // Engine port: write plus registered read
   // ------------------------------------------------------------------------
   always_ff @(posedge VGA_CTRL_CLK)
   begin
      if (mem.we)
         cells[mem.waddr.idx] <= mem.wdata;
      mem.rdata <= cells[mem.raddr.idx];   // Old data on same-address write
   end

   // ------------------------------------------------------------------------
   // Scan port, read only
   // ------------------------------------------------------------------------
   always_ff @(posedge VGA_CTRL_CLK)
   begin
      pixel_on <= cells[scan_addr.idx];   // One cycle after scan_x/scan_y
   end

endmodule

`default_nettype wire

/* dla_top.sv */
// Aggregation engine top: random source, walker, grid access and frame buffer
`timescale 1ns/1ps
`default_nettype none
`include "dla_params.svh"

module dla_top (
   input  wire logic                   VGA_CTRL_CLK,
   input  wire logic                   reset,
   input  wire logic                   run,       // Pause key, low holds
   input  wire logic [`DLA_X_BITS-1:0] scan_x,
   input  wire logic [`DLA_Y_BITS-1:0] scan_y,
   output logic                        pixel_on,
   output logic                        ready,
   output logic                        stuck,
   output logic [`DLA_X_BITS-1:0]      stuck_x,
   output logic [`DLA_Y_BITS-1:0]      stuck_y
);
   import dla_geom_pkg::*;

   logic [`DLA_XR_BITS-1:0] xr;         // Random words
   logic [`DLA_YR_BITS-1:0] yr;
   logic                    step;
   cell_addr_u              scan_addr;

   grid_req_if grid_bus ();   // Walker to grid access
   buf_port_if buf_bus ();    // Grid access to memory

   assign scan_addr.xy.x = scan_x;
   assign scan_addr.xy.y = scan_y;

   random_source u_rand (
      .VGA_CTRL_CLK (VGA_CTRL_CLK),
      .reset        (reset),
      .step         (step),
      .run          (run),
      .xr           (xr),
      .yr           (yr)
   );

   walker_ctrl u_walk (
      .VGA_CTRL_CLK (VGA_CTRL_CLK),
      .reset        (reset),
      .run          (run),
      .xr           (xr),
      .yr           (yr),
      .step         (step),
      .grid         (grid_bus.walker),
      .ready        (ready),
      .stuck        (stuck),
      .stuck_x      (stuck_x),
      .stuck_y      (stuck_y)
   );

   grid_access u_access (
      .VGA_CTRL_CLK (VGA_CTRL_CLK),
      .reset        (reset),
      .grid         (grid_bus.access),
      .mem          (buf_bus.master)
   );

   cell_buffer u_buf (
      .VGA_CTRL_CLK (VGA_CTRL_CLK),
      .mem          (buf_bus.memory),
      .scan_addr    (scan_addr),
      .pixel_on     (pixel_on)
   );

endmodule

`default_nettype wire

/* dla_chk.sv */
// Bound assertions on the grid request handshake and the stuck strobe
`timescale 1ns/1ps
`default_nettype none

module dla_chk (
   input wire logic                     clk,
   input wire logic                     reset,
   input wire logic                     req,
   input wire logic                     ack,
   input wire dla_ctrl_pkg::grid_op_t   op,
   input wire dla_geom_pkg::cell_addr_u addr,
   input wire logic                     stuck
);

   int unsigned fails = 0;   // Failed assertions so far

   // ------------------------------------------------------------------------
   // Four-phase handshake
   // ------------------------------------------------------------------------
   a_ack_after_req: assert property (@(posedge clk) disable iff (reset)
      $rose(ack) |-> req)
   else
   begin
      $error("ack rose while req was low");
      fails++;
   end

   a_req_held: assert property (@(posedge clk) disable iff (reset)
      req && !ack |=> req)   // No withdrawal before ack
   else
   begin
      $error("req dropped before ack");
      fails++;
   end

   a_cmd_stable: assert property (@(posedge clk) disable iff (reset)
      req |=> !req || ($stable(op) && $stable(addr)))
   else
   begin
      $error("op or addr changed while req was high");
      fails++;
   end

   // ------------------------------------------------------------------------
   // Event output
   // ------------------------------------------------------------------------
   a_stuck_pulse: assert property (@(posedge clk) disable iff (reset)
      stuck |=> !stuck)
   else
   begin
      $error("stuck held for more than one cycle");
      fails++;
   end

endmodule

// Grid bus and stuck output of the top level
bind dla_top dla_chk u_chk (
   .clk   (VGA_CTRL_CLK),
   .reset (reset),
   .req   (grid_bus.req),
   .ack   (grid_bus.ack),
   .op    (grid_bus.op),
   .addr  (grid_bus.addr),
   .stuck (stuck)
);

`default_nettype wire

/* tb_dla.sv */
// Directed testbench for the aggregation engine, with a grid model and a timeout
`timescale 1ns/1ps
`default_nettype none
`include "dla_params.svh"

module tb_dla;
   import dla_geom_pkg::*;

   localparam int lo_c       = `DLA_MARGIN;
   localparam int hi_x       = `DLA_GRID_W - 8;
   localparam int hi_y       = `DLA_GRID_H - 8;
   localparam int mid_x      = `DLA_GRID_W / 2;   // Seed cell
   localparam int mid_y      = `DLA_GRID_H / 2;
   localparam int n_pulses   = 8;
   localparam int pause_len  = 3000;
   localparam int scan_len   = `DLA_GRID_W * `DLA_GRID_H;
   localparam int clear_len  = scan_len + 64;      // Sweep plus seed write
   localparam int pulse_len  = 250000;             // Hitting time of one walker, with margin
   localparam int max_cycles = clear_len + 3 * scan_len + pause_len
                               + (n_pulses + 1) * pulse_len;

   logic     VGA_CTRL_CLK;
   logic     reset;
   logic     run;
   coord_x_t scan_x;
   coord_y_t scan_y;
   logic     pixel_on;
   logic     ready;
   logic     stuck;
   coord_x_t stuck_x;
   coord_y_t stuck_y;

   logic model [0:`DLA_GRID_W-1][0:`DLA_GRID_H-1];   // [x][y], set = aggregate
   int   value_errors = 0;
   int   other_errors = 0;
   int   refrozen     = 0;   // Walkers frozen onto a set cell
   int   cycles       = 0;

   dla_top u_dut (
      .VGA_CTRL_CLK (VGA_CTRL_CLK),
      .reset        (reset),
      .run          (run),
      .scan_x       (scan_x),
      .scan_y       (scan_y),
      .pixel_on     (pixel_on),
      .ready        (ready),
      .stuck        (stuck),
      .stuck_x      (stuck_x),
      .stuck_y      (stuck_y)
   );

   initial
   begin
      VGA_CTRL_CLK = 1'b0;
      forever #4 VGA_CTRL_CLK = ~VGA_CTRL_CLK;   // 8 ns period
   end

   always @(posedge VGA_CTRL_CLK)
   begin
      cycles = cycles + 1;
      if (cycles >= max_cycles)
      begin
         $display("Timeout: run stopped after %0d cycles", cycles);
         $display("test failed");
         $finish;
      end
   end

   // ------------------------------------------------------------------------
   // Compare tasks and waits
   // ------------------------------------------------------------------------
   task automatic compare_bit(input string name, input logic got, input logic exp);
      if (got !== exp)
      begin
         value_errors++;
         $display("[ERROR] %s: got %h, expected %h", name, got, exp);
      end
   endtask

   task automatic compare_x(input string name, input coord_x_t got, input coord_x_t exp);
      if (got !== exp)
      begin
         value_errors++;
         $display("[ERROR] %s: got %h, expected %h", name, got, exp);
      end
   endtask

   task automatic compare_y(input string name, input coord_y_t got, input coord_y_t exp);
      if (got !== exp)
      begin
         value_errors++;
         $display("[ERROR] %s: got %h, expected %h", name, got, exp);
      end
   endtask

   task automatic next_cycle;   // Drive and sample point, 1 ns after the edge
      @(posedge VGA_CTRL_CLK);
      #1;
   endtask

   task automatic wait_stuck;
      do
         next_cycle();
      while (!stuck);
   endtask

   // One scan address per cycle, pixel checked a cycle later
   task automatic scan_image;
      int x;
      int y;
      for (y = 0; y < `DLA_GRID_H; y++)
         for (x = 0; x < `DLA_GRID_W; x++)
         begin
            scan_x = coord_x_t'(x);
            scan_y = coord_y_t'(y);
            next_cycle();
            compare_bit($sformatf("pixel_on (%0d,%0d)", x, y), pixel_on, model[x][y]);
         end
   endtask

   // Bounds and neighbour rule, then the model update
   task automatic check_stuck;
      int   x;
      int   y;
      logic nb;
      x = stuck_x;
      y = stuck_y;
      if (x < lo_c || x > hi_x || y < lo_c || y > hi_y)
      begin
         other_errors++;
         $display("Stuck cell (%0d,%0d) lies outside the walker margins", x, y);
      end
      else
      begin
         nb = model[x-1][y] | model[x+1][y] | model[x][y-1] | model[x][y+1];
         compare_bit($sformatf("neighbour of stuck (%0d,%0d)", x, y), nb, 1'b1);
      end
      if (model[x][y])
         refrozen++;   // Diagonal step landed on the aggregate
      else
         model[x][y] = 1'b1;
   endtask

   // ------------------------------------------------------------------------
   // Directed tests
   // ------------------------------------------------------------------------
   task automatic test_seed_image;
      compare_bit("ready", ready, 1'b0);
      compare_bit("stuck", stuck, 1'b0);
      while (!ready)
         next_cycle();
      run = 1'b0;   // Hold the first walker during the scan
      model[mid_x][mid_y] = 1'b1;
      scan_image();
      compare_bit("ready", ready, 1'b1);
      run = 1'b1;
   endtask

   task automatic test_aggregation;
      int k;
      for (k = 0; k < n_pulses; k++)
      begin
         wait_stuck();
         check_stuck();
      end
   endtask

   task automatic test_pause;
      coord_x_t px;
      coord_y_t py;
      px  = stuck_x;
      py  = stuck_y;
      run = 1'b0;   // Right after a pulse, no freeze in flight
      repeat (pause_len)
      begin
         next_cycle();
         if (stuck)
         begin
            other_errors++;
            $display("Stuck pulse seen while paused");
         end
      end
      compare_x("stuck_x", stuck_x, px);
      compare_y("stuck_y", stuck_y, py);
      scan_image();
      run = 1'b1;
      wait_stuck();   // Engine resumes
      check_stuck();
      run = 1'b0;   // Freeze the image for the last scan
   endtask

   task automatic test_final_image;
      scan_image();
      compare_bit("ready", ready, 1'b1);
   endtask

   // ------------------------------------------------------------------------
   // Sequence
   // ------------------------------------------------------------------------
   initial
   begin
      for (int x = 0; x < `DLA_GRID_W; x++)
         for (int y = 0; y < `DLA_GRID_H; y++)
            model[x][y] = 1'b0;
      reset  = 1'b1;
      run    = 1'b1;
      scan_x = '0;
      scan_y = '0;
      repeat (2) @(posedge VGA_CTRL_CLK);
      #1 reset = 1'b0;

      test_seed_image();
      test_aggregation();
      test_pause();
      test_final_image();

      $display("Walkers frozen on a set cell: %0d", refrozen);
      $display("Errors: %0d value, %0d other, %0d assertion",
               value_errors, other_errors, u_dut.u_chk.fails);
      if (value_errors + other_errors + u_dut.u_chk.fails == 0)
         $display("test passed");
      else
         $display("test failed");
      $finish;
   end

endmodule

`default_nettype wire

/* files.f */
+incdir+.
dla_geom_pkg.sv
dla_ctrl_pkg.sv
dla_ifs.sv
random_source.sv
grid_access.sv
walker_ctrl.sv
cell_buffer.sv
dla_top.sv
dla_chk.sv
tb_dla.sv

/* Makefile */
# Verilator build and run of the aggregation engine testbench

SIM := obj_dir/Vtb_dla

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator and run tb_dla"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert -Wno-fatal -j 0 --top-module tb_dla -f files.f
	@out=$$(./$(SIM)); echo "$$out"; echo "$$out" | grep -qx "test passed"

clean:
	rm -rf obj_dir
